/* testbench/decode_testdata.txt */
# instr gap gen spec rd_e rj_e rk_e imm_en imm_sx st issue b_ex legal rd rj rk imm b_off name
# All hex; gap 1 allows a random idle gap of 0 to 3 cycles before the word, 0 forces none
00100c41 0 1 00 1 1 1 0 0 0 0 0 1 01 02 03 0000000 00000000 add_w
001118a4 0 1 01 1 1 1 0 0 0 0 0 1 04 05 06 0000000 00000000 sub_w
001c2507 1 1 0b 1 1 1 0 0 0 0 0 1 07 08 09 0000000 00000000 mul_w
0020316a 1 1 0e 1 1 1 0 0 0 1 0 1 0a 0b 0c 0000000 00000000 div_w
0020ffff 0 1 0f 1 1 1 0 0 0 1 0 1 1f 1f 1f 0000000 00000000 mod_w
00210000 1 1 10 1 1 1 0 0 0 1 0 1 00 00 00 0000000 00000000 divu_w
00218c41 0 1 11 1 1 1 0 0 0 1 0 1 01 02 03 0000000 00000000 modu_w
00183dcd 1 1 0a 1 1 1 0 0 0 0 0 1 0d 0e 0f 0000000 00000000 sra_w
001d1062 0 1 0d 1 1 1 0 0 0 0 0 1 02 03 04 0000000 00000000 mulh_wu
02a00041 1 2 02 1 1 0 1 1 0 0 0 1 01 02 00 0000800 00000000 addi_w
021ffc83 0 2 00 1 1 0 1 1 0 0 0 1 03 04 1f 00007ff 00000000 slti
02448cc5 1 2 01 1 1 0 1 1 0 0 0 1 05 06 03 0000123 00000000 sltui
037ffd07 0 2 03 1 1 0 1 0 0 0 0 1 07 08 1f 0000fff 00000000 andi
0382ad49 1 2 04 1 1 0 1 0 0 0 0 1 09 0a 0b 00000ab 00000000 ori
03e00000 0 2 05 1 1 0 1 0 0 0 0 1 00 00 00 0000800 00000000 xori
28804064 1 2 08 1 1 0 1 1 0 2 0 1 04 03 10 0000010 00000000 ld_w
2a3ff041 0 2 0c 1 1 0 1 1 0 2 0 1 01 02 1c 0000ffc 00000000 ld_bu
298010c5 0 2 0b 1 1 0 1 1 1 2 0 1 05 06 04 0000004 00000000 st_w
2920043f 1 2 09 1 1 0 1 1 1 2 0 1 1f 01 01 0000801 00000000 st_b
28400062 0 2 07 1 1 0 1 1 0 2 0 1 02 03 00 0000000 00000000 ld_h
50010000 1 3 01 0 0 0 1 1 0 0 1 1 00 00 00 0000000 00000100 b_forward
53fff3ff 0 3 01 0 0 0 1 1 0 0 1 1 1f 1f 1c 0000000 fffffff0 b_backward
50000200 1 3 01 0 0 0 1 1 0 0 1 1 00 10 00 0000000 f8000000 b_most_negative
548d1401 0 3 02 0 0 0 1 1 0 0 0 1 01 00 05 0012345 00000000 bl
5bffc043 1 3 03 1 1 0 1 1 0 0 0 1 03 02 10 000fff0 00000000 beq
4c000420 0 3 00 1 1 0 1 1 0 0 0 1 00 01 01 0000001 00000000 jirl
6e000085 1 3 08 1 1 0 1 1 0 0 0 1 05 04 00 0008000 00000000 bgeu
0040fc41 0 4 00 1 1 0 1 0 0 0 0 1 01 02 1f 000001f 00000000 slli_w
004894c7 1 4 02 1 1 0 1 0 0 0 0 1 07 06 05 0000005 00000000 srai_w
00448000 0 4 01 1 1 0 1 0 0 0 0 1 00 00 00 0000000 00000000 srli_w
15000004 1 5 00 1 0 0 1 1 0 0 0 1 04 00 00 3f80000 00000000 lu12i_w_negative
1c2468bf 0 5 01 1 0 0 1 1 0 0 0 1 1f 05 1a 0012345 00000000 pcaddu12i
14ffffe1 0 5 00 1 0 0 1 1 0 0 0 1 01 1f 1f 007ffff 00000000 lu12i_w_positive
04000c01 1 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 csrrd
002b0005 0 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 syscall
38720000 1 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 dbar
ffffffff 0 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 all_ones
2ac00000 1 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 preld
00000000 0 0 00 0 0 0 0 0 0 0 0 0 00 00 00 0000000 00000000 zero_word
00100c41 0 1 00 1 1 1 0 0 0 0 0 1 01 02 03 0000000 00000000 add_w_after_illegal

/* sources.f */
rtl/decode_pkg.sv
rtl/opcode_matcher.sv
rtl/decode_control.sv
rtl/operand_field_extractor.sv
rtl/decode_stage_reg.sv
rtl/decode_top.sv
testbench/decode_checker.sv
testbench/tb_decode_top.sv

/* testbench/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top;
    import decode_pkg::*;

    logic           clk;
    logic           arst_n;
    logic           instr_valid;
    instr_t         instr;
    logic           dec_valid;
    decoded_instr_t dec;

    instr_t         vec_instr[$];  // Stimulus words from the data file
    bit             vec_gap[$];    // 1 = random idle gap allowed before the word
    decoded_instr_t vec_exp[$];    // Expected bundle per word
    string          vec_name[$];   // Mnemonic for error lines
    decoded_instr_t exp_q[$];      // In-flight expectations
    decoded_instr_t last_dec;      // Bundle that dec must hold while idle
    int             vec_total;
    bit             vectors_loaded;
    int unsigned    seed;

    decode_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1, "Simulation stopped after first failure");
    endtask

    task automatic check_decoded(input string name, input decoded_instr_t exp,
                                 input decoded_instr_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected dec_valid %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    // Each line holds instr, gap hint, bundle fields in declaration order and a name
    task automatic load_vectors();
        int             fd;
        int             n;
        string          line;
        string          nm;
        logic [31:0]    c [0:17];
        decoded_instr_t e;
        fd = $fopen("testbench/decode_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file testbench/decode_testdata.txt");
            stop_on_failure();
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 10 && line.getc(0) != "#") begin  // Skip comments and blanks
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s",
                            c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
                            c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], nm);
                if (n != 19) begin
                    $display("Malformed line in the test data file: %s", line);
                    stop_on_failure();
                end
                e = {c[2][3:0], c[3][4:0], c[4][0], c[5][0], c[6][0], c[7][0],
                     c[8][0], c[9][0], c[10][1:0], c[11][0], c[12][0],
                     c[13][4:0], c[14][4:0], c[15][4:0], c[16][25:0], c[17]};
                vec_instr.push_back(c[0]);
                vec_gap.push_back(c[1][0]);
                vec_exp.push_back(e);
                vec_name.push_back(nm);
            end
        end
        $fclose(fd);
        vec_total      = vec_instr.size();
        vectors_loaded = 1'b1;
    endtask

    // One clock, then check what the previous drive produced
    task automatic step_cycle(input string name);
        logic           strobe;
        decoded_instr_t exp;
        strobe = instr_valid;
        @(negedge clk);
        check_valid(name, strobe, dec_valid);
        if (strobe) begin
            exp      = exp_q.pop_front();
            last_dec = exp;
            check_decoded(name, exp, dec);
        end else begin
            check_decoded({name, " idle hold"}, last_dec, dec);
        end
    endtask

    initial begin
        wait (vectors_loaded);
        #((vec_total * 5 + 20) * 10);  // Worst case 4 cycles per vector plus reset
        $display("Watchdog expired before all vectors were decoded");
        stop_on_failure();
    end

    initial begin
        int gap;
        seed        = 32'h3ae0_ffb1;
        void'($urandom(seed));
        arst_n      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        last_dec    = '0;  // Reset value of dec
        load_vectors();
        if (vec_total == 0) begin
            $display("The test data file holds no vectors");
            stop_on_failure();
        end
        #1 arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_valid("after reset", 1'b0, dec_valid);
        check_decoded("after reset", '0, dec);
        for (int i = 0; i < vec_total; i++) begin
            gap = vec_gap[i] ? int'($urandom % 4) : 0;  // Hint 0 keeps strobes back to back
            repeat (gap) begin
                instr_valid = 1'b0;
                instr       = $urandom;  // Must be ignored while idle
                step_cycle(vec_name[i]);
            end
            instr_valid = 1'b1;
            instr       = vec_instr[i];
            exp_q.push_back(vec_exp[i]);
            step_cycle(vec_name[i]);
        end
        instr_valid = 1'b0;
        instr       = '0;
        step_cycle("drain");
        $display("Regression passed");
        $finish;
    end

endmodule

/* testbench/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       dec_valid,
    input decode_pkg::decoded_instr_t dec
);
    import decode_pkg::*;

    // Async reset keeps the output strobe low
    a_valid_in_reset: assert property (@(posedge clk) !arst_n |-> !dec_valid)
        else $error("dec_valid high while arst_n low");

    // Illegal bundle carries no operand or branch info
    a_illegal_clear: assert property (@(posedge clk) disable iff (!arst_n)
        !dec.legal |-> !(dec.rd_exist || dec.rj_exist || dec.rk_exist ||
                         dec.imm_enable || dec.b_exist))
        else $error("Illegal bundle has exist, imm or branch flags set");

    // Only B sets b_exist
    a_b_is_bj: assert property (@(posedge clk) disable iff (!arst_n)
        dec.b_exist |-> dec.gen_op == GEN_BJ)
        else $error("b_exist set outside the BJ class");

    // LSU queue only for loads and stores
    a_lsu_is_2r12i: assert property (@(posedge clk) disable iff (!arst_n)
        dec.issue_dir == ISSUE_LSU |-> dec.gen_op == GEN_2R12I)
        else $error("ISSUE_LSU outside the 2R12I class");

endmodule

bind decode_top decode_checker u_decode_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec       (dec)
);

/* rtl/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_valid,
    input  decode_pkg::instr_t         instr,
    output logic                       dec_valid,
    output decode_pkg::decoded_instr_t dec
);
    import decode_pkg::*;

    gen_op_e      fmt;       // Matched class
    spec_op_t     spec_op;   // Op within class
    decode_ctrl_t ctrl;      // Control bundle
    operand_t     operands;  // Register and immediate fields

    opcode_matcher u_opcode_matcher (
        .instr   (instr),
        .fmt     (fmt),
        .spec_op (spec_op)
    );

    decode_control u_decode_control (
        .fmt     (fmt),
        .spec_op (spec_op),
        .ctrl    (ctrl)
    );

    operand_field_extractor u_operand_field_extractor (
        .instr    (instr),
        .imm_sel  (ctrl.imm_sel),
        .operands (operands)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .spec_op     (spec_op),
        .operands    (operands),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

endmodule

/* rtl/decode_stage_reg.sv */
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_valid,
    input  decode_pkg::decode_ctrl_t   ctrl,
    input  decode_pkg::spec_op_t       spec_op,
    input  decode_pkg::operand_t       operands,
    output logic                       dec_valid,
    output decode_pkg::decoded_instr_t dec
);
    import decode_pkg::*;

    decoded_instr_t dec_next;

    always_comb begin
        dec_next.gen_op          = ctrl.gen_op;
        dec_next.spec_op         = spec_op;
        dec_next.rd_exist        = ctrl.rd_exist;
        dec_next.rj_exist        = ctrl.rj_exist;
        dec_next.rk_exist        = ctrl.rk_exist;
        dec_next.imm_enable      = ctrl.imm_enable;
        dec_next.imm_sign_extend = ctrl.imm_sign_extend;
        dec_next.store_or_load   = ctrl.store_or_load;
        dec_next.issue_dir       = ctrl.issue_dir;
        dec_next.b_exist         = ctrl.b_exist;
        dec_next.legal           = ctrl.legal;
        // Illegal words carry no register fields downstream
        dec_next.operands        = ctrl.legal ? operands : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= instr_valid;  // One pulse per strobe
            if (instr_valid) begin
                dec <= dec_next;  // Hold last bundle when idle
            end
        end
    end

endmodule

/* rtl/operand_field_extractor.sv */
`timescale 1ns/1ps

module operand_field_extractor (
    input  decode_pkg::instr_t   instr,
    input  decode_pkg::imm_sel_e imm_sel,
    output decode_pkg::operand_t operands
);
    import decode_pkg::*;

    always_comb begin
        operands.rd            = instr[RD_LSB +: 5];  // Fixed positions in every format
        operands.rj            = instr[RJ_LSB +: 5];
        operands.rk            = instr[RK_LSB +: 5];
        operands.imm           = '0;
        operands.b_jump_offset = '0;
        case (imm_sel)
            IMM_SI12:   operands.imm = {14'b0, instr[21:10]};
            IMM_OFFS16: operands.imm = {10'b0, instr[25:10]};
            IMM_OFFS26: operands.imm = {instr[9:0], instr[25:10]};  // High part sits low
            IMM_B_OFFSET: begin
                // Word offset to bytes, then sign-extend from offs[25] (instr[9])
                operands.b_jump_offset = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};
            end
            IMM_UI5:    operands.imm = {21'b0, instr[14:10]};
            IMM_SI20:   operands.imm = {{6{instr[24]}}, instr[24:5]};
            default:    operands.imm = '0;  // IMM_NONE
        endcase
    end

endmodule

/* rtl/decode_control.sv */
`timescale 1ns/1ps

module decode_control (
    input  decode_pkg::gen_op_e      fmt,
    input  decode_pkg::spec_op_t     spec_op,
    output decode_pkg::decode_ctrl_t ctrl
);
    import decode_pkg::*;

    always_comb begin
        ctrl = '0;  // Illegal words keep everything cleared
        case (fmt)
            GEN_3R: begin
                ctrl.gen_op   = GEN_3R;
                ctrl.legal    = 1'b1;
                ctrl.rd_exist = 1'b1;
                ctrl.rj_exist = 1'b1;
                ctrl.rk_exist = 1'b1;
                ctrl.imm_sel  = IMM_NONE;
                case (spec_op)
                    OP3R_DIV_W, OP3R_DIVU_W,
                    OP3R_MOD_W, OP3R_MODU_W: ctrl.issue_dir = ISSUE_COMPLEX;  // Divider
                    default:                 ctrl.issue_dir = ISSUE_SIMPLE;
                endcase
            end
            GEN_2R12I: begin
                ctrl.gen_op          = GEN_2R12I;
                ctrl.legal           = 1'b1;
                ctrl.rd_exist        = 1'b1;
                ctrl.rj_exist        = 1'b1;
                ctrl.imm_enable      = 1'b1;
                ctrl.imm_sel         = IMM_SI12;
                ctrl.imm_sign_extend = 1'b1;  // All but the logic ops
                case (spec_op)
                    OP2R12I_ANDI, OP2R12I_ORI, OP2R12I_XORI: begin
                        ctrl.imm_sign_extend = 1'b0;  // Logic ops zero-extend
                    end
                    OP2R12I_LD_B, OP2R12I_LD_H, OP2R12I_LD_W,
                    OP2R12I_LD_BU, OP2R12I_LD_HU: begin
                        ctrl.issue_dir = ISSUE_LSU;  // Load, store_or_load stays 0
                    end
                    OP2R12I_ST_B, OP2R12I_ST_H, OP2R12I_ST_W: begin
                        ctrl.issue_dir     = ISSUE_LSU;
                        ctrl.store_or_load = 1'b1;
                    end
                    default: ctrl.issue_dir = ISSUE_SIMPLE;  // SLTI, SLTUI, ADDI
                endcase
            end
            GEN_BJ: begin
                ctrl.gen_op          = GEN_BJ;
                ctrl.legal           = 1'b1;
                ctrl.imm_enable      = 1'b1;
                ctrl.imm_sign_extend = 1'b1;  // Every branch offset is signed
                case (spec_op)
                    OPBJ_B: begin
                        ctrl.imm_sel = IMM_B_OFFSET;  // Target resolved in decode
                        ctrl.b_exist = 1'b1;
                    end
                    OPBJ_BL: ctrl.imm_sel = IMM_OFFS26;  // Link reg is implicit
                    default: begin
                        ctrl.rd_exist = 1'b1;  // JIRL and compare branches
                        ctrl.rj_exist = 1'b1;
                        ctrl.imm_sel  = IMM_OFFS16;
                    end
                endcase
            end
            GEN_2R5I: begin
                ctrl.gen_op     = GEN_2R5I;
                ctrl.legal      = 1'b1;
                ctrl.rd_exist   = 1'b1;
                ctrl.rj_exist   = 1'b1;
                ctrl.imm_enable = 1'b1;
                ctrl.imm_sel    = IMM_UI5;  // Shift amount, unsigned
            end
            GEN_1R20I: begin
                ctrl.gen_op          = GEN_1R20I;
                ctrl.legal           = 1'b1;
                ctrl.rd_exist        = 1'b1;
                ctrl.imm_enable      = 1'b1;
                ctrl.imm_sign_extend = 1'b1;
                ctrl.imm_sel         = IMM_SI20;
            end
            default: ctrl.legal = 1'b0;
        endcase
    end

endmodule

/* rtl/opcode_matcher.sv */
`timescale 1ns/1ps

module opcode_matcher (
    input  decode_pkg::instr_t   instr,
    output decode_pkg::gen_op_e  fmt,
    output decode_pkg::spec_op_t spec_op
);
    import decode_pkg::*;

    logic [4:0] class_hit;  // {3R, 2R12I, BJ, 2R5I, 1R20I}
    spec_op_t   op_3r;
    spec_op_t   op_2r12i;
    spec_op_t   op_bj;
    spec_op_t   op_2r5i;
    spec_op_t   op_1r20i;

    always_comb begin
        class_hit = 5'b11111;  // Cleared by each default arm
        case (instr[31:OPC_3R_LSB])
            OPC_ADD_W:   op_3r = OP3R_ADD_W;
            OPC_SUB_W:   op_3r = OP3R_SUB_W;
            OPC_SLT:     op_3r = OP3R_SLT;
            OPC_SLTU:    op_3r = OP3R_SLTU;
            OPC_NOR:     op_3r = OP3R_NOR;
            OPC_AND:     op_3r = OP3R_AND;
            OPC_OR:      op_3r = OP3R_OR;
            OPC_XOR:     op_3r = OP3R_XOR;
            OPC_SLL_W:   op_3r = OP3R_SLL_W;
            OPC_SRL_W:   op_3r = OP3R_SRL_W;
            OPC_SRA_W:   op_3r = OP3R_SRA_W;
            OPC_MUL_W:   op_3r = OP3R_MUL_W;
            OPC_MULH_W:  op_3r = OP3R_MULH_W;
            OPC_MULH_WU: op_3r = OP3R_MULH_WU;
            OPC_DIV_W:   op_3r = OP3R_DIV_W;
            OPC_MOD_W:   op_3r = OP3R_MOD_W;
            OPC_DIVU_W:  op_3r = OP3R_DIVU_W;
            OPC_MODU_W:  op_3r = OP3R_MODU_W;
            default: begin
                op_3r        = '0;
                class_hit[4] = 1'b0;
            end
        endcase
        case (instr[31:OPC_2R12I_LSB])
            OPC_SLTI:   op_2r12i = OP2R12I_SLTI;
            OPC_SLTUI:  op_2r12i = OP2R12I_SLTUI;
            OPC_ADDI_W: op_2r12i = OP2R12I_ADDI_W;
            OPC_ANDI:   op_2r12i = OP2R12I_ANDI;
            OPC_ORI:    op_2r12i = OP2R12I_ORI;
            OPC_XORI:   op_2r12i = OP2R12I_XORI;
            OPC_LD_B:   op_2r12i = OP2R12I_LD_B;
            OPC_LD_H:   op_2r12i = OP2R12I_LD_H;
            OPC_LD_W:   op_2r12i = OP2R12I_LD_W;
            OPC_ST_B:   op_2r12i = OP2R12I_ST_B;
            OPC_ST_H:   op_2r12i = OP2R12I_ST_H;
            OPC_ST_W:   op_2r12i = OP2R12I_ST_W;
            OPC_LD_BU:  op_2r12i = OP2R12I_LD_BU;
            OPC_LD_HU:  op_2r12i = OP2R12I_LD_HU;
            default: begin
                op_2r12i     = '0;
                class_hit[3] = 1'b0;
            end
        endcase
        case (instr[31:OPC_BJ_LSB])
            OPC_JIRL: op_bj = OPBJ_JIRL;
            OPC_B:    op_bj = OPBJ_B;
            OPC_BL:   op_bj = OPBJ_BL;
            OPC_BEQ:  op_bj = OPBJ_BEQ;
            OPC_BNE:  op_bj = OPBJ_BNE;
            OPC_BLT:  op_bj = OPBJ_BLT;
            OPC_BGE:  op_bj = OPBJ_BGE;
            OPC_BLTU: op_bj = OPBJ_BLTU;
            OPC_BGEU: op_bj = OPBJ_BGEU;
            default: begin
                op_bj        = '0;
                class_hit[2] = 1'b0;
            end
        endcase
        case (instr[31:OPC_3R_LSB])  // 2R5I shares the 3R opcode field
            OPC_SLLI_W: op_2r5i = OP2R5I_SLLI_W;
            OPC_SRLI_W: op_2r5i = OP2R5I_SRLI_W;
            OPC_SRAI_W: op_2r5i = OP2R5I_SRAI_W;
            default: begin
                op_2r5i      = '0;
                class_hit[1] = 1'b0;
            end
        endcase
        case (instr[31:OPC_1R20I_LSB])
            OPC_LU12I_W:   op_1r20i = OP1R20I_LU12I_W;
            OPC_PCADDU12I: op_1r20i = OP1R20I_PCADDU12I;
            default: begin
                op_1r20i     = '0;
                class_hit[0] = 1'b0;
            end
        endcase
    end

    // Only a single class hit is legal; none or several fall to GEN_NONE
    always_comb begin
        case (class_hit)
            5'b10000: begin
                fmt     = GEN_3R;
                spec_op = op_3r;
            end
            5'b01000: begin
                fmt     = GEN_2R12I;
                spec_op = op_2r12i;
            end
            5'b00100: begin
                fmt     = GEN_BJ;
                spec_op = op_bj;
            end
            5'b00010: begin
                fmt     = GEN_2R5I;
                spec_op = op_2r5i;
            end
            5'b00001: begin
                fmt     = GEN_1R20I;
                spec_op = op_1r20i;
            end
            default: begin
                fmt     = GEN_NONE;
                spec_op = '0;
            end
        endcase
    end

endmodule

/* rtl/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] instr_t;    // Raw instruction word
    typedef logic [4:0]  reg_idx_t;  // Architectural register index
    typedef logic [25:0] imm_t;      // Raw immediate, extended later by the FU
    typedef logic [31:0] addr_t;     // Byte offset of a direct branch
    typedef logic [4:0]  spec_op_t;  // Specific op, narrow classes zero-extended

    typedef enum logic [3:0] {
        GEN_NONE  = 4'd0,
        GEN_3R    = 4'd1,
        GEN_2R12I = 4'd2,
        GEN_BJ    = 4'd3,
        GEN_2R5I  = 4'd4,
        GEN_1R20I = 4'd5
    } gen_op_e;

    typedef enum logic [1:0] {
        ISSUE_SIMPLE  = 2'd0,
        ISSUE_COMPLEX = 2'd1,  // Mul/div unit
        ISSUE_LSU     = 2'd2
    } issue_dir_e;

    typedef enum logic [2:0] {
        IMM_NONE     = 3'd0,
        IMM_SI12     = 3'd1,  // instr[21:10]
        IMM_OFFS16   = 3'd2,  // instr[25:10]
        IMM_OFFS26   = 3'd3,  // {instr[9:0], instr[25:10]}
        IMM_B_OFFSET = 3'd4,  // Offset goes to b_jump_offset instead
        IMM_UI5      = 3'd5,  // instr[14:10]
        IMM_SI20     = 3'd6   // instr[24:5], sign-extended
    } imm_sel_e;

    // Register and opcode field positions
    localparam int RD_LSB        = 0;
    localparam int RJ_LSB        = 5;
    localparam int RK_LSB        = 10;
    localparam int OPC_3R_LSB    = 15;  // Also used by 2R5I
    localparam int OPC_2R12I_LSB = 22;
    localparam int OPC_BJ_LSB    = 26;
    localparam int OPC_1R20I_LSB = 25;

    // 3R opcodes, instr[31:15]
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_NOR     = 17'h00028;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002A;
    localparam logic [16:0] OPC_XOR     = 17'h0002B;
    localparam logic [16:0] OPC_SLL_W   = 17'h0002E;
    localparam logic [16:0] OPC_SRL_W   = 17'h0002F;
    localparam logic [16:0] OPC_SRA_W   = 17'h00030;
    localparam logic [16:0] OPC_MUL_W   = 17'h00038;
    localparam logic [16:0] OPC_MULH_W  = 17'h00039;
    localparam logic [16:0] OPC_MULH_WU = 17'h0003A;
    localparam logic [16:0] OPC_DIV_W   = 17'h00040;
    localparam logic [16:0] OPC_MOD_W   = 17'h00041;
    localparam logic [16:0] OPC_DIVU_W  = 17'h00042;
    localparam logic [16:0] OPC_MODU_W  = 17'h00043;

    // 2R5I opcodes, instr[31:15]
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    // 2R12I opcodes, instr[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_SLTUI  = 10'h009;
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC_ANDI   = 10'h00D;
    localparam logic [9:0] OPC_ORI    = 10'h00E;
    localparam logic [9:0] OPC_XORI   = 10'h00F;
    localparam logic [9:0] OPC_LD_B   = 10'h0A0;
    localparam logic [9:0] OPC_LD_H   = 10'h0A1;
    localparam logic [9:0] OPC_LD_W   = 10'h0A2;
    localparam logic [9:0] OPC_ST_B   = 10'h0A4;
    localparam logic [9:0] OPC_ST_H   = 10'h0A5;
    localparam logic [9:0] OPC_ST_W   = 10'h0A6;
    localparam logic [9:0] OPC_LD_BU  = 10'h0A8;
    localparam logic [9:0] OPC_LD_HU  = 10'h0A9;

    // BJ opcodes, instr[31:26]
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;
    localparam logic [5:0] OPC_BLT  = 6'h18;
    localparam logic [5:0] OPC_BGE  = 6'h19;
    localparam logic [5:0] OPC_BLTU = 6'h1A;
    localparam logic [5:0] OPC_BGEU = 6'h1B;

    // 1R20I opcodes, instr[31:25]
    localparam logic [6:0] OPC_LU12I_W   = 7'h0A;
    localparam logic [6:0] OPC_PCADDU12I = 7'h0E;

    // Specific op codes, numbered within each class
    localparam spec_op_t OP3R_ADD_W   = 5'd0;
    localparam spec_op_t OP3R_SUB_W   = 5'd1;
    localparam spec_op_t OP3R_SLT     = 5'd2;
    localparam spec_op_t OP3R_SLTU    = 5'd3;
    localparam spec_op_t OP3R_NOR     = 5'd4;
    localparam spec_op_t OP3R_AND     = 5'd5;
    localparam spec_op_t OP3R_OR      = 5'd6;
    localparam spec_op_t OP3R_XOR     = 5'd7;
    localparam spec_op_t OP3R_SLL_W   = 5'd8;
    localparam spec_op_t OP3R_SRL_W   = 5'd9;
    localparam spec_op_t OP3R_SRA_W   = 5'd10;
    localparam spec_op_t OP3R_MUL_W   = 5'd11;
    localparam spec_op_t OP3R_MULH_W  = 5'd12;
    localparam spec_op_t OP3R_MULH_WU = 5'd13;
    localparam spec_op_t OP3R_DIV_W   = 5'd14;
    localparam spec_op_t OP3R_MOD_W   = 5'd15;
    localparam spec_op_t OP3R_DIVU_W  = 5'd16;
    localparam spec_op_t OP3R_MODU_W  = 5'd17;

    localparam spec_op_t OP2R12I_SLTI   = 5'd0;
    localparam spec_op_t OP2R12I_SLTUI  = 5'd1;
    localparam spec_op_t OP2R12I_ADDI_W = 5'd2;
    localparam spec_op_t OP2R12I_ANDI   = 5'd3;
    localparam spec_op_t OP2R12I_ORI    = 5'd4;
    localparam spec_op_t OP2R12I_XORI   = 5'd5;
    localparam spec_op_t OP2R12I_LD_B   = 5'd6;
    localparam spec_op_t OP2R12I_LD_H   = 5'd7;
    localparam spec_op_t OP2R12I_LD_W   = 5'd8;
    localparam spec_op_t OP2R12I_ST_B   = 5'd9;
    localparam spec_op_t OP2R12I_ST_H   = 5'd10;
    localparam spec_op_t OP2R12I_ST_W   = 5'd11;
    localparam spec_op_t OP2R12I_LD_BU  = 5'd12;
    localparam spec_op_t OP2R12I_LD_HU  = 5'd13;

    localparam spec_op_t OPBJ_JIRL = 5'd0;
    localparam spec_op_t OPBJ_B    = 5'd1;
    localparam spec_op_t OPBJ_BL   = 5'd2;
    localparam spec_op_t OPBJ_BEQ  = 5'd3;
    localparam spec_op_t OPBJ_BNE  = 5'd4;
    localparam spec_op_t OPBJ_BLT  = 5'd5;
    localparam spec_op_t OPBJ_BGE  = 5'd6;
    localparam spec_op_t OPBJ_BLTU = 5'd7;
    localparam spec_op_t OPBJ_BGEU = 5'd8;

    localparam spec_op_t OP2R5I_SLLI_W = 5'd0;
    localparam spec_op_t OP2R5I_SRLI_W = 5'd1;
    localparam spec_op_t OP2R5I_SRAI_W = 5'd2;

    localparam spec_op_t OP1R20I_LU12I_W   = 5'd0;
    localparam spec_op_t OP1R20I_PCADDU12I = 5'd1;

    typedef struct packed {
        gen_op_e    gen_op;
        logic       rd_exist;
        logic       rj_exist;
        logic       rk_exist;
        logic       imm_enable;
        logic       imm_sign_extend;
        logic       store_or_load;  // 1 = store
        issue_dir_e issue_dir;
        logic       b_exist;        // Direct branch B
        imm_sel_e   imm_sel;
        logic       legal;
    } decode_ctrl_t;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        imm_t     imm;
        addr_t    b_jump_offset;
    } operand_t;

    typedef struct packed {
        gen_op_e    gen_op;
        spec_op_t   spec_op;
        logic       rd_exist;
        logic       rj_exist;
        logic       rk_exist;
        logic       imm_enable;
        logic       imm_sign_extend;
        logic       store_or_load;
        issue_dir_e issue_dir;
        logic       b_exist;
        logic       legal;
        operand_t   operands;
    } decoded_instr_t;

endpackage
